//--- tlul_lite_settings.svh
// Widths and register map constants for the TL-UL register device
// Data width is fixed at 32 bits; sizes above 4 bytes are not supported
`ifndef TLUL_LITE_SETTINGS_SVH
`define TLUL_LITE_SETTINGS_SVH

// Bus field widths
`define TL_AW  32
`define TL_DW  32
`define TL_DBW (`TL_DW/8)
`define TL_SZW 2
`define TL_AIW 8

// Register map
`define REG_NUM    8
`define REG_DEV_ID 32'h544C_0001

`endif

//--- tlul_pkg.sv
// TL-UL protocol types for a single host, A and D channels only
// No integrity bits; the user field carries only the instruction flag
`include "tlul_lite_settings.svh"

package tlul_pkg;

  typedef enum logic [2:0] {
    PutFullData    = 3'h0,
    PutPartialData = 3'h1,
    Get            = 3'h4
  } tl_a_op_e;

  typedef enum logic [2:0] {
    AccessAck     = 3'h0,
    AccessAckData = 3'h1
  } tl_d_op_e;

  // Only the exact true pattern counts as true
  typedef enum logic [3:0] {
    MuBi4True  = 4'h6,
    MuBi4False = 4'h9
  } mubi4_t;

  typedef struct packed {
    mubi4_t instr_type;
  } tl_a_user_t;

  typedef struct packed {
    logic                a_valid;
    tl_a_op_e            a_opcode;
    logic [`TL_SZW-1:0]  a_size;
    logic [`TL_AIW-1:0]  a_source;
    logic [`TL_AW-1:0]   a_address;
    logic [`TL_DBW-1:0]  a_mask;
    logic [`TL_DW-1:0]   a_data;
    tl_a_user_t          a_user;
    logic                d_ready;
  } tl_h2d_t;

  typedef struct packed {
    logic                d_valid;
    tl_d_op_e            d_opcode;
    logic [`TL_SZW-1:0]  d_size;
    logic [`TL_AIW-1:0]  d_source;
    logic [`TL_DW-1:0]   d_data;
    logic                d_error;
    logic                a_ready;
  } tl_d2h_t;

  // Payloads as held in the queues, no handshake bits
  typedef struct packed {
    tl_a_op_e            a_opcode;
    logic [`TL_SZW-1:0]  a_size;
    logic [`TL_AIW-1:0]  a_source;
    logic [`TL_AW-1:0]   a_address;
    logic [`TL_DBW-1:0]  a_mask;
    logic [`TL_DW-1:0]   a_data;
    tl_a_user_t          a_user;
  } tl_a_pl_t;

  typedef struct packed {
    tl_d_op_e            d_opcode;
    logic [`TL_SZW-1:0]  d_size;
    logic [`TL_AIW-1:0]  d_source;
    logic [`TL_DW-1:0]   d_data;
    logic                d_error;
  } tl_d_pl_t;

endpackage

//--- tlul_reg_pkg.sv
// Register map types; index width follows REG_NUM
`include "tlul_lite_settings.svh"

package tlul_reg_pkg;

  localparam int RegIdxW = $clog2(`REG_NUM);

  typedef logic [RegIdxW-1:0] reg_idx_t;

  // One register access, we low means read only
  typedef struct packed {
    logic                we;
    reg_idx_t            idx;
    logic [`TL_DBW-1:0]  be;
    logic [`TL_DW-1:0]   wdata;
  } reg_req_t;

endpackage

//--- tlul_err.sv
// A-channel legality check on a request payload, purely combinational
// Supports sizes of 1, 2 and 4 bytes on a 32-bit bus only
// Clock and reset feed the assertion and nothing else
module tlul_err import tlul_pkg::*; (
  input  logic     clk_i,
  input  logic     reset_i,
  input  tl_a_pl_t tl_i,
  output logic     err_o
);

  localparam int MW    = $bits(tl_i.a_mask);
  localparam int SubAW = $clog2(MW);

  logic op_full, op_partial, op_get;
  logic opcode_ok;
  logic instr_wr_err;
  logic addr_sz_chk;    // Size aligned to address
  logic mask_chk;       // No bits outside the active lanes
  logic fulldata_chk;   // Full mask for PutFullData
  logic [SubAW-1:0] byte_off;
  logic [MW-1:0] lane_mask;

  assign op_full    = (tl_i.a_opcode == PutFullData);
  assign op_partial = (tl_i.a_opcode == PutPartialData);
  assign op_get     = (tl_i.a_opcode == Get);
  assign opcode_ok  = op_full | op_partial | op_get;

  // Instruction fetches may only read
  assign instr_wr_err = (tl_i.a_user.instr_type == MuBi4True) & (op_full | op_partial);

  assign byte_off = tl_i.a_address[SubAW-1:0];

  always_comb begin
    lane_mask   = '0;
    addr_sz_chk = 1'b0;
    unique case (tl_i.a_size)
      2'd0: begin
        lane_mask   = MW'(1) << byte_off;
        addr_sz_chk = 1'b1;
      end
      2'd1: begin // Half word, lower or upper pair
        lane_mask   = MW'(3) << {byte_off[SubAW-1:1], 1'b0};
        addr_sz_chk = ~byte_off[0];
      end
      2'd2: begin
        lane_mask   = {MW{1'b1}};
        addr_sz_chk = ~|byte_off;
      end
      default: begin
        lane_mask   = '0;   // Bursts not supported
        addr_sz_chk = 1'b0;
      end
    endcase
  end

  assign mask_chk     = ~|(tl_i.a_mask & ~lane_mask);
  assign fulldata_chk = ((tl_i.a_mask & lane_mask) == lane_mask);

  assign err_o = ~opcode_ok
               | ~addr_sz_chk
               | ~mask_chk
               | (op_full & ~fulldata_chk)
               | instr_wr_err;

  // A legal byte access selects exactly one lane and masks at most that one
  a_byte_one_lane: assert property (@(posedge clk_i) disable iff (reset_i)
    (tl_i.a_size == 2'd0 && !err_o) |-> ($onehot(lane_mask) && $onehot0(tl_i.a_mask)));

endmodule

//--- tlul_fifo.sv
// Synchronous FIFO with valid/ready on both sides, payload type set per instance
// No fall-through: a push becomes visible on the output after its edge
module tlul_fifo #(
  parameter int  DEPTH     = 2,
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     reset_i,
  input  logic     in_valid_i,
  output logic     in_ready_o,
  input  payload_t in_data_i,
  output logic     out_valid_o,
  input  logic     out_ready_i,
  output payload_t out_data_o
);

  localparam int PtrW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CntW = $clog2(DEPTH + 1);

  payload_t        mem_q [DEPTH];
  logic [PtrW-1:0] wr_ptr_q, rd_ptr_q;
  logic [CntW-1:0] count_q;
  logic            push, pop;

  function automatic logic [PtrW-1:0] ptr_inc(input logic [PtrW-1:0] ptr);
    return (ptr == PtrW'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign out_valid_o = (count_q != '0);
  assign out_data_o  = mem_q[rd_ptr_q];
  assign pop         = out_valid_o & out_ready_i;
  assign in_ready_o  = (count_q < CntW'(DEPTH)) | pop;  // Full but draining is ok
  assign push        = in_valid_i & in_ready_o;

  always_ff @(posedge clk_i) begin
    if (push) mem_q[wr_ptr_q] <= in_data_i;
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) wr_ptr_q <= ptr_inc(wr_ptr_q);
      if (pop)  rd_ptr_q <= ptr_inc(rd_ptr_q);
      if (push && !pop)      count_q <= count_q + 1'b1;
      else if (pop && !push) count_q <= count_q - 1'b1;
    end
  end

  a_no_overflow: assert property (@(posedge clk_i) disable iff (reset_i)
    count_q <= CntW'(DEPTH));

  // Head item must hold while the consumer stalls
  a_out_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    (out_valid_o && !out_ready_i) |=> (out_valid_o && $stable(out_data_o)));

endmodule

//--- tlul_reg_file.sv
// REG_NUM 32-bit registers with byte enables; last one is a read-only ID
// Writes to the ID register are dropped without an error
`include "tlul_lite_settings.svh"

module tlul_reg_file import tlul_reg_pkg::*; (
  input  logic             clk_i,
  input  logic             reset_i,
  input  logic             req_valid_i,
  input  reg_req_t         req_i,
  output logic [`TL_DW-1:0] rdata_o
);

  localparam int NumRw = `REG_NUM - 1;

  logic [`TL_DW-1:0] regs_q [NumRw];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 0; i < NumRw; i++) regs_q[i] <= '0;
    end else if (req_valid_i && req_i.we) begin
      for (int i = 0; i < NumRw; i++) begin
        if (req_i.idx == reg_idx_t'(i)) begin
          for (int b = 0; b < `TL_DBW; b++) begin
            if (req_i.be[b]) regs_q[i][8*b +: 8] <= req_i.wdata[8*b +: 8];
          end
        end
      end
    end
  end

  // Falls back to the ID when no writable register matches
  always_comb begin
    rdata_o = `REG_DEV_ID;
    for (int i = 0; i < NumRw; i++) begin
      if (req_i.idx == reg_idx_t'(i)) rdata_o = regs_q[i];
    end
  end

endmodule

//--- tlul_reg_adapter.sv
// Turns one queued A request into a register access and a D reply
// Window is REG_NUM words from address 0; anything above is an error
`include "tlul_lite_settings.svh"

module tlul_reg_adapter import tlul_pkg::*; import tlul_reg_pkg::*; (
  input  logic             clk_i,
  input  logic             reset_i,
  input  logic             req_valid_i,
  input  tl_a_pl_t         req_i,
  output logic             req_pop_o,
  output logic             rsp_valid_o,
  input  logic             rsp_ready_i,
  output tl_d_pl_t         rsp_o,
  output logic             reg_req_valid_o,
  output reg_req_t         reg_req_o,
  input  logic [`TL_DW-1:0] reg_rdata_i
);

  localparam int WordAW = $clog2(`TL_DBW);
  localparam int WinAW  = RegIdxW + WordAW;   // 5 bits for eight words

  logic proto_err;
  logic win_err;
  logic err;
  logic is_get, is_put;
  logic accept;

  tlul_err u_err (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .tl_i    (req_i),
    .err_o   (proto_err)
  );

  assign win_err = |req_i.a_address[`TL_AW-1:WinAW];
  assign err     = proto_err | win_err;

  assign is_get = (req_i.a_opcode == Get);
  assign is_put = (req_i.a_opcode == PutFullData) | (req_i.a_opcode == PutPartialData);

  // Pop and push happen together, so both wait on room in the response queue
  assign accept      = req_valid_i & rsp_ready_i;
  assign req_pop_o   = accept;
  assign rsp_valid_o = req_valid_i;

  // Only legal accesses reach the register file
  assign reg_req_valid_o = accept & ~err;
  assign reg_req_o = '{
    we:    is_put & ~err,
    idx:   req_i.a_address[WinAW-1:WordAW],
    be:    req_i.a_mask,
    wdata: req_i.a_data
  };

  assign rsp_o = '{
    d_opcode: is_get ? AccessAckData : AccessAck,
    d_size:   req_i.a_size,
    d_source: req_i.a_source,
    d_data:   (is_get && !err) ? reg_rdata_i : '0,
    d_error:  err
  };

  // No write from an instruction fetch or from outside the window
  a_no_write_on_err: assert property (@(posedge clk_i) disable iff (reset_i)
    (reg_req_valid_o && reg_req_o.we) |->
      ((req_i.a_address < `REG_NUM * `TL_DBW) && (req_i.a_user.instr_type != MuBi4True)));

endmodule

//--- tlul_reg_top.sv
// TL-UL register device with two-entry request and response queues
// At most four requests in flight; replies come back in request order
`include "tlul_lite_settings.svh"

module tlul_reg_top import tlul_pkg::*; import tlul_reg_pkg::*; (
  input  logic    clk_i,
  input  logic    reset_i,
  input  tl_h2d_t tl_i,
  output tl_d2h_t tl_o
);

  tl_a_pl_t          req_in, req_out;
  logic              req_in_ready, req_out_valid, req_pop;
  tl_d_pl_t          rsp_in, rsp_out;
  logic              rsp_in_valid, rsp_in_ready, rsp_out_valid;
  logic              reg_req_valid;
  reg_req_t          reg_req;
  logic [`TL_DW-1:0] reg_rdata;

  assign req_in = '{
    a_opcode:  tl_i.a_opcode,
    a_size:    tl_i.a_size,
    a_source:  tl_i.a_source,
    a_address: tl_i.a_address,
    a_mask:    tl_i.a_mask,
    a_data:    tl_i.a_data,
    a_user:    tl_i.a_user
  };

  tlul_fifo #(.DEPTH(2), .payload_t(tl_a_pl_t)) req_fifo (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .in_valid_i  (tl_i.a_valid),
    .in_ready_o  (req_in_ready),
    .in_data_i   (req_in),
    .out_valid_o (req_out_valid),
    .out_ready_i (req_pop),
    .out_data_o  (req_out)
  );

  tlul_reg_adapter u_adapter (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .req_valid_i     (req_out_valid),
    .req_i           (req_out),
    .req_pop_o       (req_pop),
    .rsp_valid_o     (rsp_in_valid),
    .rsp_ready_i     (rsp_in_ready),
    .rsp_o           (rsp_in),
    .reg_req_valid_o (reg_req_valid),
    .reg_req_o       (reg_req),
    .reg_rdata_i     (reg_rdata)
  );

  tlul_reg_file u_reg_file (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .req_valid_i (reg_req_valid),
    .req_i       (reg_req),
    .rdata_o     (reg_rdata)
  );

  tlul_fifo #(.DEPTH(2), .payload_t(tl_d_pl_t)) rsp_fifo (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .in_valid_i  (rsp_in_valid),
    .in_ready_o  (rsp_in_ready),
    .in_data_i   (rsp_in),
    .out_valid_o (rsp_out_valid),
    .out_ready_i (tl_i.d_ready),
    .out_data_o  (rsp_out)
  );

  assign tl_o = '{
    d_valid:  rsp_out_valid,
    d_opcode: rsp_out.d_opcode,
    d_size:   rsp_out.d_size,
    d_source: rsp_out.d_source,
    d_data:   rsp_out.d_data,
    d_error:  rsp_out.d_error,
    a_ready:  req_in_ready
  };

endmodule

//--- tb_tlul_reg_top.sv
// Directed testbench for the TL-UL register device
// One request in flight at a time, except in the back-pressure test
`include "tlul_lite_settings.svh"

module tb_tlul_reg_top import tlul_pkg::*; ();

  localparam int ClkPeriod = 8;
  // About 150 transactions of at most 12 cycles each, with a wide margin
  localparam int MaxCycles = 5000;

  logic    clk_i;
  logic    reset_i;
  tl_h2d_t tl_i;
  tl_d2h_t tl_o;

  integer            seed = 53183;
  int                cycle_cnt = 0;
  string             test_name;
  logic [`TL_DW-1:0] model [`REG_NUM];   // Expected register contents

  tlul_reg_top DUT (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .tl_i    (tl_i),
    .tl_o    (tl_o)
  );

  initial clk_i = 1'b0;
  always #(ClkPeriod/2) clk_i = ~clk_i;

  task automatic stop_run();
    $display("ERRORS FOUND");
    $fatal(1, "Simulation stopped at the first failure");
  endtask

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == MaxCycles) begin
      $display("Timeout, the run did not finish within %0d cycles", MaxCycles);
      stop_run();
    end
  end

  function automatic logic [31:0] rand_word();
    return $random(seed);
  endfunction

  task automatic check_eq(input string what, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      $display("ERR %s %s: expected %h, actual %h", test_name, what, exp, act);
      stop_run();
    end
  endtask

  task automatic drive_a(input tl_a_op_e op, input logic [1:0] size, input logic [31:0] addr,
                         input logic [3:0] mask, input logic [31:0] data,
                         input mubi4_t instr, input logic [7:0] src);
    tl_i.a_valid           = 1'b1;
    tl_i.a_opcode          = op;
    tl_i.a_size            = size;
    tl_i.a_source          = src;
    tl_i.a_address         = addr;
    tl_i.a_mask            = mask;
    tl_i.a_data            = data;
    tl_i.a_user.instr_type = instr;
  endtask

  // Handshake happens on the edge after a_ready is seen high
  task automatic wait_a_accept();
    do begin
      @(negedge clk_i);
    end while (!tl_o.a_ready);
    @(posedge clk_i);
    #1;
    tl_i.a_valid = 1'b0;
  endtask

  task automatic recv_rsp(output tl_d2h_t rsp);
    do begin
      @(negedge clk_i);
    end while (!tl_o.d_valid);
    rsp = tl_o;
    @(posedge clk_i);
    #1;
  endtask

  task automatic tl_access(input tl_a_op_e op, input logic [1:0] size, input logic [31:0] addr,
                           input logic [3:0] mask, input logic [31:0] data,
                           input mubi4_t instr, input logic exp_err);
    logic [7:0]  src;
    logic [2:0]  idx;
    logic [31:0] exp_data;
    tl_d2h_t     rsp;
    src = 8'($random(seed));
    idx = addr[4:2];
    drive_a(op, size, addr, mask, data, instr, src);
    wait_a_accept();
    recv_rsp(rsp);
    exp_data = (op == Get && !exp_err) ? model[idx] : '0;
    check_eq("d_error", 32'(exp_err), 32'(rsp.d_error));
    check_eq("d_opcode", (op == Get) ? 32'(AccessAckData) : 32'(AccessAck),
             32'(rsp.d_opcode));
    check_eq("d_source", 32'(src), 32'(rsp.d_source));
    check_eq("d_size", 32'(size), 32'(rsp.d_size));
    check_eq("d_data", exp_data, rsp.d_data);
    // Register 7 is read-only
    if (op != Get && !exp_err && idx != 3'd7) begin
      for (int b = 0; b < 4; b++) begin
        if (mask[b]) model[idx][8*b +: 8] = data[8*b +: 8];
      end
    end
  endtask

  task automatic tl_put(input tl_a_op_e op, input logic [1:0] size, input logic [31:0] addr,
                        input logic [3:0] mask, input logic [31:0] data, input logic exp_err);
    tl_access(op, size, addr, mask, data, MuBi4False, exp_err);
  endtask

  task automatic tl_get(input logic [31:0] addr, input logic exp_err);
    tl_access(Get, 2'd2, addr, 4'hF, '0, MuBi4False, exp_err);
  endtask

  task automatic test_reset();
    test_name = "test_reset";
    @(negedge clk_i);
    check_eq("a_ready", 32'd1, 32'(tl_o.a_ready));
    check_eq("d_valid", 32'd0, 32'(tl_o.d_valid));
    @(posedge clk_i);
    #1;
    for (int i = 0; i < `REG_NUM; i++) tl_get(32'(4*i), 1'b0);
  endtask

  task automatic test_full_write();
    test_name = "test_full_write";
    for (int i = 0; i < `REG_NUM - 1; i++) begin
      tl_put(PutFullData, 2'd2, 32'(4*i), 4'hF, rand_word(), 1'b0);
    end
    for (int i = 0; i < `REG_NUM; i++) tl_get(32'(4*i), 1'b0);
    tl_put(PutFullData, 2'd2, 32'h1C, 4'hF, rand_word(), 1'b0);  // ID stays
    tl_get(32'h1C, 1'b0);
  endtask

  task automatic test_partial();
    logic [1:0] off;
    test_name = "test_partial";
    for (int round = 0; round < 2; round++) begin
      for (int i = 0; i < `REG_NUM - 1; i++) begin
        off = 2'($random(seed));
        tl_put(PutPartialData, 2'd0, 32'(4*i) + off, 4'b0001 << off, rand_word(), 1'b0);
        off = {1'($random(seed)), 1'b0};   // Half word, lower or upper pair
        tl_put(PutPartialData, 2'd1, 32'(4*i) + off, 4'b0011 << off, rand_word(), 1'b0);
        tl_put(PutPartialData, 2'd2, 32'(4*i), 4'($random(seed)), rand_word(), 1'b0);
        tl_get(32'(4*i), 1'b0);
      end
    end
  endtask

  task automatic test_errors();
    test_name = "test_errors";
    tl_put(tl_a_op_e'(3'h2), 2'd2, 32'h04, 4'hF, rand_word(), 1'b1);  // Undefined opcode
    tl_get(32'h04, 1'b0);
    // Misaligned word and half word
    tl_put(PutFullData, 2'd2, 32'h0A, 4'hF, rand_word(), 1'b1);
    tl_get(32'h08, 1'b0);
    tl_put(PutPartialData, 2'd1, 32'h0D, 4'b0110, rand_word(), 1'b1);
    tl_get(32'h0C, 1'b0);
    tl_get(32'h06, 1'b1);
    // Mask bits outside the addressed lanes
    tl_put(PutPartialData, 2'd0, 32'h10, 4'b0010, rand_word(), 1'b1);
    tl_put(PutPartialData, 2'd1, 32'h12, 4'b0001, rand_word(), 1'b1);
    tl_get(32'h10, 1'b0);
    tl_put(PutFullData, 2'd2, 32'h14, 4'b0111, rand_word(), 1'b1);  // Short mask
    tl_get(32'h14, 1'b0);
    // Instruction fetch may read but not write
    tl_access(PutFullData, 2'd2, 32'h18, 4'hF, rand_word(), MuBi4True, 1'b1);
    tl_get(32'h18, 1'b0);
    tl_access(Get, 2'd2, 32'h18, 4'hF, '0, MuBi4True, 1'b0);
    // Outside the 32-byte window
    tl_put(PutFullData, 2'd2, 32'h20, 4'hF, rand_word(), 1'b1);
    tl_put(PutFullData, 2'd2, 32'h8000_0004, 4'hF, rand_word(), 1'b1);
    tl_get(32'h00, 1'b0);
    tl_get(32'h04, 1'b0);
    tl_get(32'h40, 1'b1);
  endtask

  task automatic test_backpressure();
    logic [7:0]  src_q [$];
    logic [31:0] data_q [$];
    logic [7:0]  src_base;
    logic [7:0]  exp_src;
    logic [31:0] exp_data;
    logic [2:0]  idx;
    int          accepted;
    int          received;
    bit          stalled;
    bit          pend_done;
    test_name = "test_backpressure";
    accepted = 0;
    received = 0;
    stalled = 1'b0;
    src_base = 8'($random(seed));
    tl_i.d_ready = 1'b0;
    // Reads back to back until a_ready falls; the last one stays pending
    while (!stalled && accepted < 8) begin
      idx = 3'($random(seed));
      drive_a(Get, 2'd2, {27'd0, idx, 2'b00}, 4'hF, '0, MuBi4False, src_base + 8'(accepted));
      src_q.push_back(src_base + 8'(accepted));
      data_q.push_back(model[idx]);
      @(negedge clk_i);
      if (tl_o.a_ready) begin
        accepted++;
        @(posedge clk_i);
        #1;
      end else begin
        stalled = 1'b1;
      end
    end
    assert (stalled && accepted <= 4) else begin
      $display("ERR %s accepted: expected at most 4 before a_ready fell, actual %0d",
               test_name, accepted);
      stop_run();
    end
    @(posedge clk_i);
    #1;
    tl_i.d_ready = 1'b1;
    while (received < accepted + 1) begin
      @(negedge clk_i);
      pend_done = tl_i.a_valid && tl_o.a_ready;
      if (tl_o.d_valid) begin
        exp_src  = src_q.pop_front();
        exp_data = data_q.pop_front();
        check_eq("d_source", 32'(exp_src), 32'(tl_o.d_source));
        check_eq("d_data", exp_data, tl_o.d_data);
        check_eq("d_error", 32'd0, 32'(tl_o.d_error));
        received++;
      end
      @(posedge clk_i);
      #1;
      if (pend_done) tl_i.a_valid = 1'b0;
    end
  endtask

  initial begin
    for (int i = 0; i < `REG_NUM - 1; i++) model[i] = '0;
    model[`REG_NUM-1] = `REG_DEV_ID;
    tl_i = '0;
    tl_i.a_user.instr_type = MuBi4False;
    tl_i.d_ready = 1'b1;
    reset_i = 1'b1;
    repeat (2) @(posedge clk_i);
    #1;
    reset_i = 1'b0;
    test_reset();
    test_full_write();
    test_partial();
    test_errors();
    test_backpressure();
    $display("NO ERRORS");
    $finish;
  end

endmodule

//--- tlul_reg.f
+incdir+.
tlul_pkg.sv
tlul_reg_pkg.sv
tlul_err.sv
tlul_fifo.sv
tlul_reg_file.sv
tlul_reg_adapter.sv
tlul_reg_top.sv
tb_tlul_reg_top.sv

//--- Bender.yml
package:
  name: tlul_reg

sources:
  - include_dirs:
      - .
    files:
      - tlul_pkg.sv
      - tlul_reg_pkg.sv
      - tlul_err.sv
      - tlul_fifo.sv
      - tlul_reg_file.sv
      - tlul_reg_adapter.sv
      - tlul_reg_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_tlul_reg_top.sv
